// ==== core_ctrl.f ====
source/ctrl_pkg.sv
source/exc_arbiter.sv
source/irq_arbiter.sv
source/ctrl_fsm.sv
source/core_ctrl.sv
dv/core_ctrl_props.sv
dv/core_ctrl_tb.sv

// ==== dv/core_ctrl_props.sv ====
////////////////////
// concurrent checks on the controller FSM
// bound into every ctrl_fsm instance
////////////////////

`timescale 1ns/1ps

module core_ctrl_props (
  input logic                  clk_i,
  input logic                  rst_ni,
  input ctrl_pkg::ctrl_state_e state_i,
  input ctrl_pkg::ctrl_state_e state_next_i,
  input logic                  instr_valid_i,
  input logic                  pc_set_i,
  input ctrl_pkg::pc_sel_e     pc_mux_i,
  input logic                  csr_save_cause_i
);
  import ctrl_pkg::*;

  // only the eight encoded states may be held
  state_legal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {RESET, BOOT_SET, FIRST_FETCH, DECODE, FLUSH, IRQ_TAKEN, WAIT_SLEEP, SLEEP})
    else $error("controller state register holds an undefined encoding");

  // irq entry never drops an instruction sitting in ID
  irq_entry_no_instr: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_next_i == IRQ_TAKEN) |-> !instr_valid_i)
    else $error("IRQ_TAKEN entered with a valid instruction in ID");

  // every trap entry must also write mcause
  exc_saves_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (pc_set_i && (pc_mux_i == PC_EXC)) |-> csr_save_cause_i)
    else $error("trap pc set without a cause save");

endmodule

bind ctrl_fsm core_ctrl_props u_core_ctrl_props (
  .clk_i            (clk_i),
  .rst_ni           (rst_ni),
  .state_i          (state_q),
  .state_next_i     (state_d),
  .instr_valid_i    (instr_valid_i),
  .pc_set_i         (pc_set_o),
  .pc_mux_i         (pc_mux_o),
  .csr_save_cause_i (csr_save_cause_o)
);

// ==== dv/core_ctrl_tb.sv ====
////////////////////
// testbench of the core controller
// LFSR driven trap, branch, irq and sleep scenarios against a model
////////////////////

`timescale 1ns/1ps

module core_ctrl_tb;
  import ctrl_pkg::*;

  localparam int TIMEOUT = 50;
  localparam int NUM_TXN = 400;

  logic clk;
  logic rst_n;

  // DUT inputs
  instr_t          instr;
  dec_flags_t      dec_flags;
  priv_lvl_e       priv;
  logic            stall_id;
  logic            branch_set;
  logic            jump_set;
  logic            load_err;
  logic            store_err;
  logic [31:0]     lsu_addr;
  irqs_t           irqs;
  logic            irq_nm;
  logic            mie;

  // DUT outputs
  logic            pc_set;
  pc_sel_e         pc_mux;
  logic            instr_req;
  logic            id_in_ready;
  logic            instr_valid_clear;
  logic            flush_id;
  logic            ctrl_busy;
  logic            csr_save_if;
  logic            csr_save_id;
  logic            csr_save_cause;
  logic            csr_restore_mret;
  exc_cause_t      exc_cause;
  logic [31:0]     csr_mtval;
  logic            nmi_mode;

  logic [31:0]     lfsr_q;
  logic            nmi_mode_m;

  core_ctrl u_core_ctrl (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .instr_i             (instr),
    .dec_flags_i         (dec_flags),
    .priv_mode_i         (priv),
    .stall_id_i          (stall_id),
    .branch_set_i        (branch_set),
    .jump_set_i          (jump_set),
    .load_err_i          (load_err),
    .store_err_i         (store_err),
    .lsu_addr_i          (lsu_addr),
    .irqs_i              (irqs),
    .irq_nm_i            (irq_nm),
    .mstatus_mie_i       (mie),
    .pc_set_o            (pc_set),
    .pc_mux_o            (pc_mux),
    .instr_req_o         (instr_req),
    .id_in_ready_o       (id_in_ready),
    .instr_valid_clear_o (instr_valid_clear),
    .flush_id_o          (flush_id),
    .ctrl_busy_o         (ctrl_busy),
    .csr_save_if_o       (csr_save_if),
    .csr_save_id_o       (csr_save_id),
    .csr_save_cause_o    (csr_save_cause),
    .csr_restore_mret_o  (csr_restore_mret),
    .exc_cause_o         (exc_cause),
    .csr_mtval_o         (csr_mtval),
    .nmi_mode_o          (nmi_mode)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  ////////////////////
  // helpers
  ////////////////////

  // x^32 + x^22 + x^2 + x + 1, one step per bit
  function automatic logic rand_bit();
    lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
    return lfsr_q[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAILED at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic idle_inputs();
    instr      = '0;
    dec_flags  = '0;
    priv       = PRIV_LVL_M;
    stall_id   = 1'b0;
    branch_set = 1'b0;
    jump_set   = 1'b0;
    load_err   = 1'b0;
    store_err  = 1'b0;
    lsu_addr   = '0;
    irqs       = '0;
    irq_nm     = 1'b0;
    mie        = 1'b0;
  endtask

  // entered on a falling edge, leaves on one with the FSM in DECODE
  task automatic wait_decode();
    int n;
    n = 0;
    while (u_core_ctrl.u_ctrl_fsm.state_q != DECODE) begin
      if (n == TIMEOUT) begin
        $display("timeout while waiting for the FSM to return to DECODE");
        stop_run();
      end
      n++;
      @(negedge clk);
    end
  endtask

  ////////////////////
  // scenarios
  ////////////////////

  task automatic run_boot();
    rst_n = 1'b0;
    repeat (2) @(negedge clk);
    #1;
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));
    check_val("instr_req_o", 32'(instr_req), 32'd0);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    // first cycle out of reset, boot address only
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));
    check_val("instr_req_o", 32'(instr_req), 32'd0);
    check_val("ctrl_busy_o", 32'(ctrl_busy), 32'd1);
    check_val("flush_id_o", 32'(flush_id), 32'd0);
    check_val("nmi_mode_o", 32'(nmi_mode), 32'd0);
    check_val("csr_save_cause_o", 32'(csr_save_cause), 32'd0);
    check_val("csr_restore_mret_o", 32'(csr_restore_mret), 32'd0);
    @(negedge clk);
    #1;
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_BOOT));
    check_val("instr_req_o", 32'(instr_req), 32'd1);
    @(negedge clk);
    wait_decode();
  endtask

  task automatic run_exception();
    logic [5:0]  exp_cause;
    logic [31:0] exp_mtval;
    // each source on a quarter of the runs
    instr.valid           = 1'b1;
    instr.fetch_err       = (rand_bits(2) == 32'd0);
    dec_flags.illegal     = (rand_bits(2) == 32'd0);
    dec_flags.ecall       = (rand_bits(2) == 32'd0);
    dec_flags.ebrk        = (rand_bits(2) == 32'd0);
    load_err              = (rand_bits(2) == 32'd0);
    store_err             = (rand_bits(2) == 32'd0);
    if (!(instr.fetch_err | dec_flags.illegal | dec_flags.ecall | dec_flags.ebrk |
          load_err | store_err)) begin
      dec_flags.illegal = 1'b1;
    end
    instr.raw             = rand_bits(32);
    instr.compressed      = 16'(rand_bits(16));
    instr.is_compressed   = rand_bit();
    instr.fetch_err_plus2 = rand_bit();
    instr.pc              = {31'(rand_bits(31)), 1'b0};
    lsu_addr              = rand_bits(32);
    priv                  = rand_bit() ? PRIV_LVL_M : PRIV_LVL_U;

    // model, fixed priority and mtval per cause
    exp_mtval = 32'd0;
    if (instr.fetch_err) begin
      exp_cause = {1'b0, 5'd1};
      exp_mtval = instr.fetch_err_plus2 ? instr.pc + 32'd2 : instr.pc;
    end else if (dec_flags.illegal) begin
      exp_cause = {1'b0, 5'd2};
      exp_mtval = instr.is_compressed ? {16'd0, instr.compressed} : instr.raw;
    end else if (dec_flags.ecall) begin
      exp_cause = (priv == PRIV_LVL_M) ? {1'b0, 5'd11} : {1'b0, 5'd8};
    end else if (dec_flags.ebrk) begin
      exp_cause = {1'b0, 5'd3};
    end else if (store_err) begin
      exp_cause = {1'b0, 5'd7};
      exp_mtval = lsu_addr;
    end else begin
      exp_cause = {1'b0, 5'd5};
      exp_mtval = lsu_addr;
    end

    #1;
    // instruction is retained in ID
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    check_val("id_in_ready_o", 32'(id_in_ready), 32'd0);
    check_val("instr_valid_clear_o", 32'(instr_valid_clear), 32'd0);
    @(negedge clk);
    #1;
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_EXC));
    check_val("csr_save_id_o", 32'(csr_save_id), 32'd1);
    check_val("csr_save_cause_o", 32'(csr_save_cause), 32'd1);
    check_val("exc_cause_o", 32'(exc_cause), 32'(exp_cause));
    check_val("csr_mtval_o", csr_mtval, exp_mtval);
    @(negedge clk);
    idle_inputs();
    wait_decode();
  endtask

  task automatic run_branch();
    instr.valid = 1'b1;
    instr.pc    = rand_bits(32);
    branch_set  = rand_bit();
    jump_set    = rand_bit();
    stall_id    = rand_bit();
    #1;
    // zero latency redirect
    check_val("pc_set_o", 32'(pc_set), 32'(branch_set | jump_set));
    if (branch_set | jump_set) begin
      check_val("pc_mux_o", 32'(pc_mux), 32'(PC_JUMP));
    end
    check_val("id_in_ready_o", 32'(id_in_ready), 32'(!stall_id));
    check_val("instr_valid_clear_o", 32'(instr_valid_clear), 32'(!stall_id));
    @(negedge clk);
    idle_inputs();
    wait_decode();
  endtask

  task automatic run_irq();
    logic       take;
    logic       found;
    logic [5:0] exp_cause;
    irqs.software = (rand_bits(2) == 32'd0);
    irqs.timer    = (rand_bits(2) == 32'd0);
    irqs.external = (rand_bits(2) == 32'd0);
    irqs.fast     = (rand_bits(2) == 32'd0) ? 15'(rand_bits(15) & rand_bits(15)) : '0;
    irq_nm        = (rand_bits(3) == 32'd0);
    mie           = rand_bit();
    priv          = rand_bit() ? PRIV_LVL_M : PRIV_LVL_U;

    // model, enable rule and cause priority
    take = !nmi_mode_m && (irq_nm || ((irqs != '0) && (mie || priv == PRIV_LVL_U)));
    found = 1'b0;
    exp_cause = {1'b1, 5'd7};
    if (irq_nm) begin
      exp_cause = {1'b1, 5'd31};
    end else if (irqs.fast != '0) begin
      for (int i = 0; i < NUM_FAST_IRQ; i++) begin
        if (irqs.fast[i] && !found) begin
          found     = 1'b1;
          exp_cause = {1'b1, 5'(16 + i)};
        end
      end
    end else if (irqs.external) begin
      exp_cause = {1'b1, 5'd11};
    end else if (irqs.software) begin
      exp_cause = {1'b1, 5'd3};
    end

    #1;
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    @(negedge clk);
    #1;
    check_val("pc_set_o", 32'(pc_set), 32'(take));
    if (take) begin
      check_val("pc_mux_o", 32'(pc_mux), 32'(PC_EXC));
      check_val("csr_save_if_o", 32'(csr_save_if), 32'd1);
      check_val("csr_save_cause_o", 32'(csr_save_cause), 32'd1);
      check_val("exc_cause_o", 32'(exc_cause), 32'(exp_cause));
      if (irq_nm) begin
        nmi_mode_m = 1'b1;
      end
    end
    @(negedge clk);
    idle_inputs();
    #1;
    check_val("nmi_mode_o", 32'(nmi_mode), 32'(nmi_mode_m));
    @(negedge clk);
    wait_decode();
  endtask

  task automatic run_mret();
    instr.valid    = 1'b1;
    dec_flags.mret = 1'b1;
    #1;
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    check_val("id_in_ready_o", 32'(id_in_ready), 32'd0);
    @(negedge clk);
    #1;
    check_val("pc_set_o", 32'(pc_set), 32'd1);
    check_val("pc_mux_o", 32'(pc_mux), 32'(PC_ERET));
    check_val("csr_restore_mret_o", 32'(csr_restore_mret), 32'd1);
    @(negedge clk);
    idle_inputs();
    nmi_mode_m = 1'b0;
    #1;
    check_val("nmi_mode_o", 32'(nmi_mode), 32'd0);
    @(negedge clk);
    wait_decode();
  endtask

  task automatic run_wfi();
    int n;
    int k;
    instr.valid   = 1'b1;
    dec_flags.wfi = 1'b1;
    @(negedge clk);
    #1;
    // flush only, no redirect
    check_val("pc_set_o", 32'(pc_set), 32'd0);
    check_val("flush_id_o", 32'(flush_id), 32'd1);
    @(negedge clk);
    idle_inputs();
    #1;
    check_val("ctrl_busy_o", 32'(ctrl_busy), 32'd0);
    k = 2 + int'(rand_bits(2));
    repeat (k) begin
      @(negedge clk);
      #1;
      check_val("ctrl_busy_o", 32'(ctrl_busy), 32'd0);
    end
    @(negedge clk);
    // wake ignores the enables
    irqs   = 18'(rand_bits(18));
    irq_nm = rand_bit();
    if (irqs == '0) begin
      irq_nm = 1'b1;
    end
    n = 0;
    #1;
    while (!ctrl_busy) begin
      if (n == TIMEOUT) begin
        $display("ctrl_busy_o did not return after a wake request");
        stop_run();
      end
      n++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    idle_inputs();
    wait_decode();
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    logic [2:0] kind;
    lfsr_q     = 32'd92495;
    nmi_mode_m = 1'b0;
    idle_inputs();
    run_boot();
    for (int t = 0; t < NUM_TXN; t++) begin
      kind = 3'(rand_bits(3));
      case (kind)
        3'd0, 3'd1, 3'd7: run_exception();
        3'd2:             run_branch();
        3'd3, 3'd4:       run_irq();
        3'd5:             run_mret();
        default:          run_wfi();
      endcase
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the core controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  --top-module core_ctrl_tb \
  -f core_ctrl.f \
  -o sim_core_ctrl

# the simulator exits non-zero on a fatal error, tee keeps the log anyway
./obj_dir/sim_core_ctrl | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  exit 0
else
  echo "simulation did not report a pass, see sim.log"
  exit 1
fi

// ==== source/core_ctrl.sv ====
////////////////////
// top of the core controller, connects the exception arbiter,
// the interrupt arbiter and the FSM
////////////////////

`timescale 1ns/1ps

module core_ctrl (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  ctrl_pkg::instr_t          instr_i,
  input  ctrl_pkg::dec_flags_t      dec_flags_i,
  input  ctrl_pkg::priv_lvl_e       priv_mode_i,
  input  logic                      stall_id_i,
  input  logic                      branch_set_i,
  input  logic                      jump_set_i,
  input  logic                      load_err_i,
  input  logic                      store_err_i,
  input  logic [ctrl_pkg::XLEN-1:0] lsu_addr_i,
  input  ctrl_pkg::irqs_t           irqs_i,
  input  logic                      irq_nm_i,
  input  logic                      mstatus_mie_i,
  output logic                      pc_set_o,
  output ctrl_pkg::pc_sel_e         pc_mux_o,
  output logic                      instr_req_o,
  output logic                      id_in_ready_o,
  output logic                      instr_valid_clear_o,
  output logic                      flush_id_o,
  output logic                      ctrl_busy_o,
  output logic                      csr_save_if_o,
  output logic                      csr_save_id_o,
  output logic                      csr_save_cause_o,
  output logic                      csr_restore_mret_o,
  output ctrl_pkg::exc_cause_t      exc_cause_o,
  output logic [ctrl_pkg::XLEN-1:0] csr_mtval_o,
  output logic                      nmi_mode_o
);
  import ctrl_pkg::*;

  // exception arbiter to FSM
  special_t        special;
  exc_cause_t      exc_cause;
  logic [XLEN-1:0] exc_mtval;
  logic            in_flush;

  // interrupt arbiter and FSM
  logic            handle_irq;
  logic            wake;
  exc_cause_t      irq_cause;
  logic            nmi_take;
  logic            mret_take;

  exc_arbiter u_exc_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .instr_i     (instr_i),
    .dec_flags_i (dec_flags_i),
    .priv_mode_i (priv_mode_i),
    .load_err_i  (load_err_i),
    .store_err_i (store_err_i),
    .lsu_addr_i  (lsu_addr_i),
    .in_flush_i  (in_flush),
    .special_o   (special),
    .exc_cause_o (exc_cause),
    .exc_mtval_o (exc_mtval)
  );

  irq_arbiter u_irq_arbiter (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irqs_i        (irqs_i),
    .irq_nm_i      (irq_nm_i),
    .mstatus_mie_i (mstatus_mie_i),
    .priv_mode_i   (priv_mode_i),
    .nmi_take_i    (nmi_take),
    .mret_take_i   (mret_take),
    .handle_irq_o  (handle_irq),
    .wake_o        (wake),
    .irq_cause_o   (irq_cause),
    .nmi_mode_o    (nmi_mode_o)
  );

  ctrl_fsm u_ctrl_fsm (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .instr_valid_i       (instr_i.valid),
    .stall_id_i          (stall_id_i),
    .branch_set_i        (branch_set_i),
    .jump_set_i          (jump_set_i),
    .special_i           (special),
    .exc_cause_i         (exc_cause),
    .exc_mtval_i         (exc_mtval),
    .handle_irq_i        (handle_irq),
    .wake_i              (wake),
    .irq_cause_i         (irq_cause),
    .nmi_mode_i          (nmi_mode_o),
    .in_flush_o          (in_flush),
    .nmi_take_o          (nmi_take),
    .mret_take_o         (mret_take),
    .pc_set_o            (pc_set_o),
    .pc_mux_o            (pc_mux_o),
    .instr_req_o         (instr_req_o),
    .id_in_ready_o       (id_in_ready_o),
    .instr_valid_clear_o (instr_valid_clear_o),
    .flush_id_o          (flush_id_o),
    .ctrl_busy_o         (ctrl_busy_o),
    .csr_save_if_o       (csr_save_if_o),
    .csr_save_id_o       (csr_save_id_o),
    .csr_save_cause_o    (csr_save_cause_o),
    .csr_restore_mret_o  (csr_restore_mret_o),
    .exc_cause_o         (exc_cause_o),
    .csr_mtval_o         (csr_mtval_o)
  );

endmodule

// ==== source/ctrl_fsm.sv ====
////////////////////
// controller FSM of the core, boot, decode, flush, irq entry and sleep
// also owns the stall control of the IF-ID register
////////////////////

`timescale 1ns/1ps

module ctrl_fsm (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      instr_valid_i,
  input  logic                      stall_id_i,
  input  logic                      branch_set_i,
  input  logic                      jump_set_i,
  input  ctrl_pkg::special_t        special_i,
  input  ctrl_pkg::exc_cause_t      exc_cause_i,
  input  logic [ctrl_pkg::XLEN-1:0] exc_mtval_i,
  input  logic                      handle_irq_i,
  input  logic                      wake_i,
  input  ctrl_pkg::exc_cause_t      irq_cause_i,
  input  logic                      nmi_mode_i,
  output logic                      in_flush_o,
  output logic                      nmi_take_o,
  output logic                      mret_take_o,
  output logic                      pc_set_o,
  output ctrl_pkg::pc_sel_e         pc_mux_o,
  output logic                      instr_req_o,
  output logic                      id_in_ready_o,
  output logic                      instr_valid_clear_o,
  output logic                      flush_id_o,
  output logic                      ctrl_busy_o,
  output logic                      csr_save_if_o,
  output logic                      csr_save_id_o,
  output logic                      csr_save_cause_o,
  output logic                      csr_restore_mret_o,
  output ctrl_pkg::exc_cause_t      exc_cause_o,
  output logic [ctrl_pkg::XLEN-1:0] csr_mtval_o
);
  import ctrl_pkg::*;

  ctrl_state_e state_q, state_d;

  logic special_req;
  logic halt_if;
  logic retain_id;
  logic flush_id;

  // anything that needs the FLUSH state
  assign special_req = special_i.exc_req | special_i.mret | special_i.flush_only;

  ////////////////////
  // next state     //
  ////////////////////

  always_comb begin
    state_d            = state_q;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    ctrl_busy_o        = 1'b1;
    halt_if            = 1'b0;
    retain_id          = 1'b0;
    flush_id           = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_restore_mret_o = 1'b0;
    exc_cause_o        = '0;
    csr_mtval_o        = '0;
    nmi_take_o         = 1'b0;
    mret_take_o        = 1'b0;

    unique case (state_q)
      RESET: begin
        // boot address loaded, no fetch yet
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        state_d     = BOOT_SET;
      end

      BOOT_SET: begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      FIRST_FETCH: begin
        // wait out the IF miss
        if (!stall_id_i) begin
          state_d = DECODE;
        end
        // nothing in ID yet, irq goes at once
        if (handle_irq_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end

      DECODE: begin
        // mux set early, only matters with pc_set
        pc_mux_o = PC_JUMP;

        if (special_req) begin
          // keep the instruction in ID for FLUSH
          retain_id = 1'b1;
          state_d   = FLUSH;
        end

        if (branch_set_i || jump_set_i) begin
          pc_set_o = 1'b1;
        end

        // let the instruction in ID finish before the irq
        if (handle_irq_i && (stall_id_i || instr_valid_i)) begin
          halt_if = 1'b1;
        end

        if (!stall_id_i && !special_req && !instr_valid_i && handle_irq_i) begin
          halt_if = 1'b1;
          state_d = IRQ_TAKEN;
        end
      end

      IRQ_TAKEN: begin
        pc_mux_o = PC_EXC;
        // request may have dropped meanwhile
        if (handle_irq_i) begin
          pc_set_o         = 1'b1;
          csr_save_if_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = irq_cause_i;
          nmi_take_o       = (irq_cause_i == CAUSE_IRQ_NM);
        end
        state_d = DECODE;
      end

      FLUSH: begin
        halt_if  = 1'b1;
        flush_id = 1'b1;
        state_d  = DECODE;

        if (special_i.exc_pending) begin
          // exception, save the ID pc and the cause
          pc_set_o         = 1'b1;
          pc_mux_o         = PC_EXC;
          csr_save_id_o    = 1'b1;
          csr_save_cause_o = 1'b1;
          exc_cause_o      = exc_cause_i;
          csr_mtval_o      = exc_mtval_i;
        end else if (special_i.mret) begin
          pc_set_o           = 1'b1;
          pc_mux_o           = PC_ERET;
          csr_restore_mret_o = 1'b1;
          // leaves the NMI handler
          mret_take_o        = nmi_mode_i;
        end else if (special_i.wfi) begin
          state_d = WAIT_SLEEP;
        end
        // csr flush only drains the pipe
      end

      WAIT_SLEEP: begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        state_d     = SLEEP;
      end

      SLEEP: begin
        instr_req_o = 1'b0;
        halt_if     = 1'b1;
        flush_id    = 1'b1;
        if (wake_i) begin
          state_d = FIRST_FETCH;
        end else begin
          // clock may stay gated
          ctrl_busy_o = 1'b0;
        end
      end

      default: begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= RESET;
    end else begin
      state_q <= state_d;
    end
  end

  assign in_flush_o = (state_q == FLUSH);
  assign flush_id_o = flush_id;

  ////////////////////
  // stall control  //
  ////////////////////

  assign id_in_ready_o = ~stall_id_i & ~halt_if & ~retain_id;

  // retain keeps valid set unless a flush overrides it
  assign instr_valid_clear_o = ~(stall_id_i | retain_id) | flush_id;

endmodule

// ==== source/ctrl_pkg.sv ====
////////////////////
// shared types and constants of the core controller
// import with ctrl_pkg::* inside a module, scoped names in port lists
////////////////////

package ctrl_pkg;

  // widths
  localparam int XLEN         = 32;
  localparam int NUM_FAST_IRQ = 15;
  localparam int FAST_ID_W    = 4;

  // controller FSM states
  typedef enum logic [3:0] {
    RESET,
    BOOT_SET,
    FIRST_FETCH,
    DECODE,
    FLUSH,
    IRQ_TAKEN,
    WAIT_SLEEP,
    SLEEP
  } ctrl_state_e;

  // fetch address source for a pc set
  typedef enum logic [1:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET
  } pc_sel_e;

  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // mcause layout, irq flag on top of the 5-bit code
  typedef struct packed {
    logic       irq;
    logic [4:0] code;
  } exc_cause_t;

  // synchronous exceptions
  localparam exc_cause_t CAUSE_FETCH_FAULT = '{irq: 1'b0, code: 5'd1};
  localparam exc_cause_t CAUSE_ILLEGAL     = '{irq: 1'b0, code: 5'd2};
  localparam exc_cause_t CAUSE_BREAKPOINT  = '{irq: 1'b0, code: 5'd3};
  localparam exc_cause_t CAUSE_LOAD_FAULT  = '{irq: 1'b0, code: 5'd5};
  localparam exc_cause_t CAUSE_STORE_FAULT = '{irq: 1'b0, code: 5'd7};
  localparam exc_cause_t CAUSE_ECALL_U     = '{irq: 1'b0, code: 5'd8};
  localparam exc_cause_t CAUSE_ECALL_M     = '{irq: 1'b0, code: 5'd11};

  // interrupts, fast irq i maps to code 16+i
  localparam exc_cause_t CAUSE_IRQ_SOFT  = '{irq: 1'b1, code: 5'd3};
  localparam exc_cause_t CAUSE_IRQ_TIMER = '{irq: 1'b1, code: 5'd7};
  localparam exc_cause_t CAUSE_IRQ_EXT   = '{irq: 1'b1, code: 5'd11};
  localparam exc_cause_t CAUSE_IRQ_NM    = '{irq: 1'b1, code: 5'd31};

  // contents of the IF-ID pipeline register
  typedef struct packed {
    logic            valid;
    logic [31:0]     raw;
    logic [15:0]     compressed;
    logic            is_compressed;
    logic            fetch_err;
    logic            fetch_err_plus2;
    logic [XLEN-1:0] pc;
  } instr_t;

  // decoder flags, not yet qualified with valid
  typedef struct packed {
    logic illegal;
    logic ecall;
    logic ebrk;
    logic mret;
    logic wfi;
    logic csr_flush;
  } dec_flags_t;

  // interrupt requests already masked by mie
  typedef struct packed {
    logic                    software;
    logic                    timer;
    logic                    external;
    logic [NUM_FAST_IRQ-1:0] fast;
  } irqs_t;

  // qualified special requests toward the FSM
  typedef struct packed {
    logic exc_req;
    logic exc_pending;
    logic mret;
    logic wfi;
    logic flush_only;
  } special_t;

endpackage

// ==== source/exc_arbiter.sv ====
////////////////////
// exception arbiter, qualifies decoder flags and registers the requests
// cause and mtval are consumed by the FSM while it sits in FLUSH
////////////////////

`timescale 1ns/1ps

module exc_arbiter (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  ctrl_pkg::instr_t               instr_i,
  input  ctrl_pkg::dec_flags_t           dec_flags_i,
  input  ctrl_pkg::priv_lvl_e            priv_mode_i,
  input  logic                           load_err_i,
  input  logic                           store_err_i,
  input  logic [ctrl_pkg::XLEN-1:0]      lsu_addr_i,
  input  logic                           in_flush_i,
  output ctrl_pkg::special_t             special_o,
  output ctrl_pkg::exc_cause_t           exc_cause_o,
  output logic [ctrl_pkg::XLEN-1:0]      exc_mtval_o
);
  import ctrl_pkg::*;

  logic ecall;
  logic ebrk;
  logic mret;
  logic wfi;
  logic csr_flush;
  logic fetch_err;

  logic illegal_d, illegal_q;
  logic exc_req_d, exc_req_q;
  logic load_err_d, load_err_q;
  logic store_err_d, store_err_q;
  logic exc_req_lsu;

  ////////////////////
  // qualification  //
  ////////////////////

  // the decoder ignores valid, so factor it in here
  assign ecall     = dec_flags_i.ecall     & instr_i.valid;
  assign ebrk      = dec_flags_i.ebrk      & instr_i.valid;
  assign mret      = dec_flags_i.mret      & instr_i.valid;
  assign wfi       = dec_flags_i.wfi       & instr_i.valid;
  assign csr_flush = dec_flags_i.csr_flush & instr_i.valid;
  assign fetch_err = instr_i.fetch_err     & instr_i.valid;

  // illegal goes through a flop to break the path from the csr file
  assign illegal_d = dec_flags_i.illegal & instr_i.valid & ~in_flush_i;

  // requests drop while flushing so a handled one is not seen again
  assign exc_req_d   = (ecall | ebrk | illegal_d | fetch_err) & ~in_flush_i;
  assign load_err_d  = load_err_i  & ~in_flush_i;
  assign store_err_d = store_err_i & ~in_flush_i;

  // lsu errors arrive without an instruction valid
  assign exc_req_lsu = load_err_i | store_err_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      illegal_q   <= 1'b0;
      exc_req_q   <= 1'b0;
      load_err_q  <= 1'b0;
      store_err_q <= 1'b0;
    end else begin
      illegal_q   <= illegal_d;
      exc_req_q   <= exc_req_d;
      load_err_q  <= load_err_d;
      store_err_q <= store_err_d;
    end
  end

  // special requests toward the FSM
  assign special_o.exc_req     = exc_req_d | exc_req_lsu;
  assign special_o.exc_pending = exc_req_q | load_err_q | store_err_q;
  assign special_o.mret        = mret;
  assign special_o.wfi         = wfi;
  // no pc change for these, only a pipeline flush
  assign special_o.flush_only  = wfi | csr_flush;

  ////////////////////
  // cause, mtval   //
  ////////////////////

  // fixed priority, decode side before the lsu errors
  always_comb begin
    exc_cause_o = '0;
    exc_mtval_o = '0;
    if (fetch_err) begin
      exc_cause_o = CAUSE_FETCH_FAULT;
      // fault in the upper half of an unaligned fetch
      exc_mtval_o = instr_i.fetch_err_plus2 ? instr_i.pc + XLEN'(2) : instr_i.pc;
    end else if (illegal_q) begin
      exc_cause_o = CAUSE_ILLEGAL;
      exc_mtval_o = instr_i.is_compressed ? XLEN'(instr_i.compressed) : instr_i.raw;
    end else if (ecall) begin
      exc_cause_o = (priv_mode_i == PRIV_LVL_M) ? CAUSE_ECALL_M : CAUSE_ECALL_U;
    end else if (ebrk) begin
      exc_cause_o = CAUSE_BREAKPOINT;
    end else if (store_err_q) begin
      exc_cause_o = CAUSE_STORE_FAULT;
      exc_mtval_o = lsu_addr_i;
    end else if (load_err_q) begin
      exc_cause_o = CAUSE_LOAD_FAULT;
      exc_mtval_o = lsu_addr_i;
    end
  end

endmodule

// ==== source/irq_arbiter.sv ====
////////////////////
// interrupt arbiter with NMI mode
// decides whether an irq is taken, its cause, and when sleep ends
////////////////////

`timescale 1ns/1ps

module irq_arbiter (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  ctrl_pkg::irqs_t      irqs_i,
  input  logic                 irq_nm_i,
  input  logic                 mstatus_mie_i,
  input  ctrl_pkg::priv_lvl_e  priv_mode_i,
  input  logic                 nmi_take_i,
  input  logic                 mret_take_i,
  output logic                 handle_irq_o,
  output logic                 wake_o,
  output ctrl_pkg::exc_cause_t irq_cause_o,
  output logic                 nmi_mode_o
);
  import ctrl_pkg::*;

  logic                 irq_enabled;
  logic                 irq_pending;
  logic                 nmi_mode_q;
  logic [FAST_ID_W-1:0] fast_id;

  // mie only masks interrupts in machine mode
  assign irq_enabled = mstatus_mie_i | (priv_mode_i == PRIV_LVL_U);

  assign irq_pending = irqs_i.software | irqs_i.timer | irqs_i.external | (|irqs_i.fast);

  // nested NMIs are not supported, NMI mode blocks everything
  assign handle_irq_o = ~nmi_mode_q & (irq_nm_i | (irq_pending & irq_enabled));

  // wake ignores the enables, as WFI requires
  assign wake_o = irq_nm_i | irq_pending;

  // lowest index fast irq wins
  always_comb begin
    fast_id = '0;
    for (int i = NUM_FAST_IRQ - 1; i >= 0; i--) begin
      if (irqs_i.fast[i]) begin
        fast_id = FAST_ID_W'(i);
      end
    end
  end

  always_comb begin
    if (irq_nm_i) begin
      irq_cause_o = CAUSE_IRQ_NM;
    end else if (irqs_i.fast != '0) begin
      // upper code bit adds 16 to the fast id
      irq_cause_o = '{irq: 1'b1, code: {1'b1, fast_id}};
    end else if (irqs_i.external) begin
      irq_cause_o = CAUSE_IRQ_EXT;
    end else if (irqs_i.software) begin
      irq_cause_o = CAUSE_IRQ_SOFT;
    end else begin
      // only the timer is left
      irq_cause_o = CAUSE_IRQ_TIMER;
    end
  end

  ////////////////////
  // NMI mode       //
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      nmi_mode_q <= 1'b0;
    end else if (nmi_take_i) begin
      nmi_mode_q <= 1'b1;
    end else if (mret_take_i) begin
      // handler has returned
      nmi_mode_q <= 1'b0;
    end
  end

  assign nmi_mode_o = nmi_mode_q;

endmodule
